// ==== src/xbar_settings.svh ====
/*
 * crossbar router settings
 * port counts, flit and payload widths, queue depth and per-input flow-control mode
 */
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// port counts, outputs must be more than one
`define XBAR_N_IN 4
`define XBAR_N_OUT 4

// low bits of every flit select the output
`define XBAR_DEST_W 2
`define XBAR_FLIT_W 16

// flit width minus the destination bits
`define XBAR_PAYLOAD_W 14

`define XBAR_FIFO_DEPTH 2
`define XBAR_DROP_HEADER 1

// one bit per input, set means credit mode
`define XBAR_CREDIT_MASK 4'b0101

`endif

// ==== src/xbar_flit_pkg.sv ====
/*
 * flit format package
 * destination id in the low bits, payload above it
 */
`include "xbar_settings.svh"

package xbar_flit_pkg;

  // output selected by a flit
  typedef logic [`XBAR_DEST_W-1:0] dest_t;

  // what leaves the router once the header is dropped
  typedef logic [`XBAR_PAYLOAD_W-1:0] payload_t;

  // whole flit as it enters an input port
  typedef struct packed {
    payload_t payload;
    dest_t    dest;
  } flit_t;

endpackage

// ==== src/xbar_ctrl_pkg.sv ====
/*
 * arbitration package
 * request, grant and grant-matrix types of the crossbar control
 */
`include "xbar_settings.svh"

package xbar_ctrl_pkg;

  // one bit per input port
  typedef logic [`XBAR_N_IN-1:0] in_vec_t;

  // one bit per output port
  typedef logic [`XBAR_N_OUT-1:0] out_vec_t;

  // row per output, one-hot over the inputs
  typedef in_vec_t [`XBAR_N_OUT-1:0] grant_mat_t;

endpackage

// ==== src/xbar_input_fifo.sv ====
/*
 * input queue of the crossbar
 * small circular buffer with valid/ready on the write side and valid/yumi on the read side
 */
module xbar_input_fifo #(
  parameter type T_DATA = logic [7:0],
  parameter int  DEPTH  = 2
) (
  input  logic  clk_i,
  input  logic  i_rst,

  input  logic  i_valid,
  output logic  o_ready,
  input  T_DATA i_data,

  output logic  o_valid,
  output T_DATA o_data,
  input  logic  i_yumi
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T_DATA            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_write;
  logic             do_read;

  // ready only from occupancy, never from the read strobe
  assign o_ready  = (count != CNT_W'(DEPTH));
  assign o_valid  = (count != '0);
  assign do_write = i_valid & o_ready;
  assign do_read  = i_yumi;

  assign o_data = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy holds when both happen together
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== src/xbar_ctrl.sv ====
/*
 * crossbar control
 * per-output round-robin arbitration over the queue heads, gives grants,
 * output valids and the dequeue strobes
 */
`include "xbar_settings.svh"

module xbar_ctrl (
  input  logic                                        clk_i,
  input  logic                                        i_rst,

  input  xbar_ctrl_pkg::in_vec_t                      i_valid,
  input  xbar_flit_pkg::dest_t [`XBAR_N_IN-1:0]       i_dest,
  output xbar_ctrl_pkg::in_vec_t                      o_yumi,

  input  xbar_ctrl_pkg::out_vec_t                     i_ready,
  output xbar_ctrl_pkg::out_vec_t                     o_valid,
  output xbar_ctrl_pkg::grant_mat_t                   o_grants
);

  localparam int N_IN  = `XBAR_N_IN;
  localparam int N_OUT = `XBAR_N_OUT;
  localparam int IN_W  = (N_IN > 1) ? $clog2(N_IN) : 1;

  xbar_ctrl_pkg::grant_mat_t req;
  xbar_ctrl_pkg::grant_mat_t grants;

  // head flits asking for each output
  always_comb begin
    for (int o = 0; o < N_OUT; o++) begin
      for (int i = 0; i < N_IN; i++) begin
        req[o][i] = i_valid[i] && (i_dest[i] == xbar_flit_pkg::dest_t'(o));
      end
    end
  end

  for (genvar o = 0; o < N_OUT; o++) begin : g_arb
    logic [IN_W-1:0]        last_q;
    logic [IN_W-1:0]        win_idx;
    logic                   hold_q;
    logic [IN_W-1:0]        hold_idx_q;
    xbar_ctrl_pkg::in_vec_t grant;

    // a stalled output keeps its winner, otherwise the search starts
    // one past the last winner and wraps
    always_comb begin
      logic [IN_W-1:0] idx;
      logic            found;
      grant   = '0;
      win_idx = last_q;
      found   = hold_q;
      if (hold_q) begin
        grant[hold_idx_q] = 1'b1;
        win_idx           = hold_idx_q;
      end
      for (int k = 1; k <= N_IN; k++) begin
        idx = IN_W'((int'(last_q) + k) % N_IN);
        if (!found && req[o][idx]) begin
          grant[idx] = 1'b1;
          win_idx    = idx;
          found      = 1'b1;
        end
      end
    end

    assign grants[o]  = grant;
    assign o_valid[o] = |req[o];

    // pointer moves only on a completed transfer
    always_ff @(posedge clk_i) begin
      if (i_rst) begin
        last_q     <= IN_W'(N_IN - 1);
        hold_q     <= 1'b0;
        hold_idx_q <= '0;
      end else begin
        // winner stays granted until its flit is taken
        hold_q     <= o_valid[o] && !i_ready[o];
        hold_idx_q <= win_idx;
        if (o_valid[o] && i_ready[o]) begin
          last_q <= win_idx;
        end
      end
    end
  end

  assign o_grants = grants;

  // an input leaves when its granted output takes the flit
  always_comb begin
    o_yumi = '0;
    for (int o = 0; o < N_OUT; o++) begin
      o_yumi = o_yumi | (grants[o] & {N_IN{i_ready[o]}});
    end
  end

endmodule

// ==== src/xbar_out_mux.sv ====
/*
 * crossbar output mux
 * drops the destination bits and steers each granted payload to its output
 */
`include "xbar_settings.svh"

module xbar_out_mux (
  input  xbar_flit_pkg::flit_t     [`XBAR_N_IN-1:0]  i_data,
  input  xbar_ctrl_pkg::grant_mat_t                  i_grants,
  output xbar_flit_pkg::payload_t  [`XBAR_N_OUT-1:0] o_data
);

  xbar_flit_pkg::payload_t [`XBAR_N_IN-1:0] head_payload;

  for (genvar i = 0; i < `XBAR_N_IN; i++) begin : g_strip
    if (`XBAR_DROP_HEADER) begin : g_drop
      assign head_payload[i] = i_data[i].payload;
    end else begin : g_keep
      // header stays in the low bits of the output word
      assign head_payload[i] = i_data[i][`XBAR_PAYLOAD_W-1:0];
    end
  end

  // and-or select, grants are one-hot per output
  always_comb begin
    for (int o = 0; o < `XBAR_N_OUT; o++) begin
      o_data[o] = '0;
      for (int i = 0; i < `XBAR_N_IN; i++) begin
        o_data[o] = o_data[o] | ({`XBAR_PAYLOAD_W{i_grants[o][i]}} & head_payload[i]);
      end
    end
  end

endmodule

// ==== src/xbar_router.sv ====
/*
 * crossbar router top
 * input queues with credit or ready flow control, round-robin control
 * and the output mux
 */
`include "xbar_settings.svh"

module xbar_router (
  input  logic                                         clk_i,
  input  logic                                         i_rst,

  input  xbar_ctrl_pkg::in_vec_t                       i_valid,
  input  xbar_flit_pkg::flit_t    [`XBAR_N_IN-1:0]     i_data,
  output xbar_ctrl_pkg::in_vec_t                       o_credit_ready,

  output xbar_ctrl_pkg::out_vec_t                      o_valid,
  output xbar_flit_pkg::payload_t [`XBAR_N_OUT-1:0]    o_data,
  input  xbar_ctrl_pkg::out_vec_t                      i_ready
);

  localparam logic [`XBAR_N_IN-1:0] CREDIT_MASK = `XBAR_CREDIT_MASK;

  if (`XBAR_N_OUT <= 1) begin : g_check
    $error("xbar_router needs more than one output");
  end

  xbar_ctrl_pkg::in_vec_t                      fifo_ready;
  xbar_ctrl_pkg::in_vec_t                      fifo_valid;
  xbar_flit_pkg::flit_t [`XBAR_N_IN-1:0]       fifo_data;
  xbar_ctrl_pkg::in_vec_t                      fifo_yumi;
  xbar_flit_pkg::dest_t [`XBAR_N_IN-1:0]       head_dest;
  xbar_ctrl_pkg::grant_mat_t                   grants;

  for (genvar i = 0; i < `XBAR_N_IN; i++) begin : g_in
    xbar_input_fifo #(
      .T_DATA (xbar_flit_pkg::flit_t),
      .DEPTH  (`XBAR_FIFO_DEPTH)
    ) u_fifo (
      .clk_i   (clk_i),
      .i_rst   (i_rst),
      .i_valid (i_valid[i]),
      .o_ready (fifo_ready[i]),
      .i_data  (i_data[i]),
      .o_valid (fifo_valid[i]),
      .o_data  (fifo_data[i]),
      .i_yumi  (fifo_yumi[i])
    );

    // low bits of the head pick the output
    assign head_dest[i] = fifo_data[i].dest;

    if (CREDIT_MASK[i]) begin : g_credit
      logic credit_q;

      // one pulse per dequeued flit, a cycle late
      always_ff @(posedge clk_i) begin
        if (i_rst) begin
          credit_q <= 1'b0;
        end else begin
          credit_q <= fifo_yumi[i];
        end
      end
      assign o_credit_ready[i] = credit_q;
    end else begin : g_ready
      assign o_credit_ready[i] = fifo_ready[i];
    end
  end

  xbar_ctrl u_ctrl (
    .clk_i    (clk_i),
    .i_rst    (i_rst),
    .i_valid  (fifo_valid),
    .i_dest   (head_dest),
    .o_yumi   (fifo_yumi),
    .i_ready  (i_ready),
    .o_valid  (o_valid),
    .o_grants (grants)
  );

  xbar_out_mux u_mux (
    .i_data   (fifo_data),
    .i_grants (grants),
    .o_data   (o_data)
  );

endmodule

// ==== dv/xbar_router_props.sv ====
/*
 * handshake properties of the crossbar router
 * stalled outputs, queue overflow and the ready level of ready-mode inputs
 */
`include "xbar_settings.svh"

module xbar_router_props (
  input logic                                         clk_i,
  input logic                                         i_rst,
  input xbar_ctrl_pkg::in_vec_t                       i_valid,
  input xbar_ctrl_pkg::in_vec_t                       i_fifo_ready,
  input xbar_ctrl_pkg::in_vec_t                       i_credit_ready,
  input xbar_ctrl_pkg::out_vec_t                      i_out_valid,
  input xbar_ctrl_pkg::out_vec_t                      i_out_ready,
  input xbar_flit_pkg::payload_t [`XBAR_N_OUT-1:0]    i_out_data
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [`XBAR_N_IN-1:0] CREDIT_MASK = `XBAR_CREDIT_MASK;

  int unsigned fail_cnt = 0;

  for (genvar o = 0; o < `XBAR_N_OUT; o++) begin : g_out
    // a stalled output stays valid and holds its payload
    a_stall_hold: assert property (@(posedge clk_i) disable iff (i_rst)
      i_out_valid[o] && !i_out_ready[o] |=> i_out_valid[o] && $stable(i_out_data[o]))
      else begin
        $error("output %0d dropped or changed a stalled flit", o);
        fail_cnt++;
      end
  end

  for (genvar i = 0; i < `XBAR_N_IN; i++) begin : g_in
    a_no_overflow: assert property (@(posedge clk_i) disable iff (i_rst)
      i_valid[i] |-> i_fifo_ready[i])
      else begin
        $error("input %0d wrote into a full queue", i);
        fail_cnt++;
      end

    if (!CREDIT_MASK[i]) begin : g_ready
      // the level only drops after a write filled the queue
      a_ready_drop: assert property (@(posedge clk_i) disable iff (i_rst)
        $fell(i_credit_ready[i]) |-> $past(i_valid[i]))
        else begin
          $error("input %0d ready level dropped without a write", i);
          fail_cnt++;
        end
    end
  end

endmodule

bind xbar_router xbar_router_props u_props (
  .clk_i          (clk_i),
  .i_rst          (i_rst),
  .i_valid        (i_valid),
  .i_fifo_ready   (fifo_ready),
  .i_credit_ready (o_credit_ready),
  .i_out_valid    (o_valid),
  .i_out_ready    (i_ready),
  .i_out_data     (o_data)
);

// ==== dv/xbar_router_tb.sv ====
/*
 * testbench of the crossbar router
 * random traffic on all inputs under ready and credit flow control, scoreboard
 * per input and output pair, round-robin fairness and credit return checks
 */
`include "xbar_settings.svh"

module xbar_router_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_IN            = `XBAR_N_IN;
  localparam int N_OUT           = `XBAR_N_OUT;
  localparam int FLIT_W          = `XBAR_FLIT_W;
  localparam int PAY_W           = `XBAR_PAYLOAD_W;
  localparam int DEST_W          = `XBAR_DEST_W;
  localparam int DEPTH           = `XBAR_FIFO_DEPTH;
  localparam int SRC_W           = $clog2(N_IN);
  localparam int CLK_HALF        = 4;
  localparam int RST_CYCLES      = 16;
  localparam int N_FLITS         = 200;
  localparam int TOTAL           = N_IN * N_FLITS;
  // hot spot phase, every input aims at output 0 with the sinks always ready
  localparam int HOT_FLITS       = 32;
  localparam int HOT_CYCLES      = 150;
  localparam int WATCHDOG_CYCLES = N_IN * N_FLITS * N_OUT + RST_CYCLES;
  localparam logic [N_IN-1:0] CREDIT_MASK = `XBAR_CREDIT_MASK;
  localparam logic [31:0]     SEED        = 32'hf4c3279d;

  logic                                clk;
  logic                                i_rst;
  xbar_ctrl_pkg::in_vec_t              i_valid;
  xbar_flit_pkg::flit_t [N_IN-1:0]     i_data;
  xbar_ctrl_pkg::in_vec_t              o_credit_ready;
  xbar_ctrl_pkg::out_vec_t             o_valid;
  xbar_flit_pkg::payload_t [N_OUT-1:0] o_data;
  xbar_ctrl_pkg::out_vec_t             i_ready;

  // expected payloads, one queue per input and output pair
  logic [PAY_W-1:0] exp_q [N_IN*N_OUT][$];
  // destinations in queue order per input, front is the modelled head
  int               dest_q [N_IN][$];
  logic [N_IN-1:0]  req_snap [N_OUT];
  int               wait_cnt [N_OUT*N_IN];
  int               sent [N_IN];
  int               credits [N_IN];
  int               total_sent;
  int               rx_count;
  int               cycle;
  int               tail;

  xbar_router dut0 (
    .clk_i          (clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .i_data         (i_data),
    .o_credit_ready (o_credit_ready),
    .o_valid        (o_valid),
    .o_data         (o_data),
    .i_ready        (i_ready)
  );

  always #(CLK_HALF) clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // outputs carry the flit without its destination bits
  function automatic logic [PAY_W-1:0] expected_payload(input logic [FLIT_W-1:0] flit);
    return flit[FLIT_W-1 -: PAY_W];
  endfunction

  task automatic check_after_reset();
    assert (o_valid == '0)
      else stop_on_error($sformatf("FAILED o_valid: got 0x%h expected 0x0", o_valid));
    // empty queues, so ready level high and no credit pulses
    assert (o_credit_ready == ~CREDIT_MASK)
      else stop_on_error($sformatf("FAILED o_credit_ready: got 0x%h expected 0x%h",
                                   o_credit_ready, ~CREDIT_MASK));
  endtask

  task automatic drive_cycle();
    logic [PAY_W-1:0] pay;
    int               dest;
    logic             allowed;
    for (int i = 0; i < N_IN; i++) begin
      if (CREDIT_MASK[i] && o_credit_ready[i]) begin
        credits[i]++;
        assert (credits[i] <= DEPTH)
          else stop_on_error($sformatf("input %0d got back more credits than it spent", i));
      end
      allowed    = CREDIT_MASK[i] ? (credits[i] > 0) : o_credit_ready[i];
      i_valid[i] = 1'b0;
      if (allowed && sent[i] < N_FLITS && $urandom_range(3, 0) != 0) begin
        pay = PAY_W'($urandom());
        // source id in the top bits keeps the queue heads of one output distinct
        pay[PAY_W-1 -: SRC_W] = SRC_W'(i);
        dest = (sent[i] < HOT_FLITS) ? 0 : int'($urandom_range(N_OUT - 1, 0));
        i_data[i]  = {pay, xbar_flit_pkg::dest_t'(dest)};
        i_valid[i] = 1'b1;
        sent[i]++;
        total_sent++;
        if (CREDIT_MASK[i]) begin
          credits[i]--;
        end
      end
    end
    for (int o = 0; o < N_OUT; o++) begin
      i_ready[o] = (cycle < HOT_CYCLES) ? 1'b1 : ($urandom_range(3, 0) != 0);
    end
    cycle++;
  endtask

  task automatic record_accept(input int s);
    int d;
    d = int'(i_data[s][DEST_W-1:0]);
    exp_q[s*N_OUT + d].push_back(expected_payload(i_data[s]));
    dest_q[s].push_back(d);
  endtask

  task automatic check_transfer(input int o);
    int src;
    int q;
    src = -1;
    for (int s = 0; s < N_IN; s++) begin
      q = s * N_OUT + o;
      if (exp_q[q].size() > 0 && exp_q[q][0] == o_data[o]) begin
        src = s;
      end
    end
    assert (src >= 0)
      else stop_on_error($sformatf("FAILED o_data[%0d]: got 0x%h, matches no expected head",
                                   o, o_data[o]));
    assert (dest_q[src][0] == o)
      else stop_on_error($sformatf("input %0d sent a flit to output %0d ahead of older flits",
                                   src, o));
    // every other requester of this output waited one more transfer
    for (int s = 0; s < N_IN; s++) begin
      if (s != src && req_snap[o][s]) begin
        wait_cnt[o*N_IN + s]++;
        assert (wait_cnt[o*N_IN + s] < N_IN)
          else stop_on_error($sformatf("input %0d waited more than %0d transfers on output %0d",
                                       s, N_IN - 1, o));
      end
    end
    wait_cnt[o*N_IN + src] = 0;
    void'(exp_q[src*N_OUT + o].pop_front());
    void'(dest_q[src].pop_front());
    rx_count++;
  endtask

  always @(posedge clk) begin : compare
    if (!i_rst) begin
      for (int o = 0; o < N_OUT; o++) begin
        for (int s = 0; s < N_IN; s++) begin
          req_snap[o][s] = (dest_q[s].size() > 0) && (dest_q[s][0] == o);
        end
        assert (o_valid[o] == |req_snap[o])
          else stop_on_error($sformatf("FAILED o_valid[%0d]: got 0x%h expected 0x%h",
                                       o, o_valid[o], |req_snap[o]));
      end
      // ready-mode inputs stay ready while the modelled queue has room
      for (int s = 0; s < N_IN; s++) begin
        if (!CREDIT_MASK[s]) begin
          assert (o_credit_ready[s] == (dest_q[s].size() < DEPTH))
            else stop_on_error($sformatf("FAILED o_credit_ready[%0d]: got 0x%h expected 0x%h",
                                         s, o_credit_ready[s], dest_q[s].size() < DEPTH));
        end
      end
      for (int o = 0; o < N_OUT; o++) begin
        if (o_valid[o] && i_ready[o]) begin
          check_transfer(o);
        end
      end
      // flits written at this edge join the model after the transfers
      for (int s = 0; s < N_IN; s++) begin
        if (i_valid[s]) begin
          record_accept(s);
        end
      end
    end
  end

  always @(negedge clk) begin : props_watch
    if (dut0.u_props.fail_cnt != 0) begin
      stop_on_error("a bound property of the router failed during the run");
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    stop_on_error($sformatf("timeout, traffic did not drain within %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin : main
    void'($urandom(SEED));
    clk        = 1'b0;
    i_rst      = 1'b1;
    i_valid    = '0;
    i_data     = '0;
    i_ready    = '0;
    total_sent = 0;
    rx_count   = 0;
    cycle      = 0;
    tail       = 0;
    for (int i = 0; i < N_IN; i++) begin
      sent[i]    = 0;
      credits[i] = CREDIT_MASK[i] ? DEPTH : 0;
    end
    for (int k = 0; k < N_OUT * N_IN; k++) begin
      wait_cnt[k] = 0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;
    @(negedge clk);
    check_after_reset();
    // a few extra cycles after the last transfer collect the last credits
    while (tail < 3) begin
      drive_cycle();
      if (total_sent == TOTAL && rx_count == TOTAL) begin
        tail++;
      end
      @(negedge clk);
    end
    for (int i = 0; i < N_IN; i++) begin
      if (CREDIT_MASK[i]) begin
        assert (credits[i] == DEPTH)
          else stop_on_error($sformatf("FAILED o_credit_ready[%0d] credits: got 0x%h expected 0x%h",
                                       i, credits[i], DEPTH));
      end
    end
    if (dut0.u_props.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_on_error("a bound property of the router failed during the run");
    end
  end

endmodule

// ==== flist.f ====
+incdir+src
src/xbar_flit_pkg.sv
src/xbar_ctrl_pkg.sv
src/xbar_input_fifo.sv
src/xbar_ctrl.sv
src/xbar_out_mux.sv
src/xbar_router.sv
dv/xbar_router_props.sv
dv/xbar_router_tb.sv

// ==== Bender.yml ====
package:
  name: xbar_router

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/xbar_flit_pkg.sv
      - src/xbar_ctrl_pkg.sv
      - src/xbar_input_fifo.sv
      - src/xbar_ctrl.sv
      - src/xbar_out_mux.sv
      - src/xbar_router.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/xbar_router_props.sv
      - dv/xbar_router_tb.sv
